/* design/icache_ctrl.sv */
// request FSM steering lookups, starting fills, installing lines and answering the CPU
`default_nettype none

module icache_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               mem_req_i,
  input  icache_pkg::addr_t  mem_adr_i,
  output logic               mem_ack_o,
  output logic               mem_err_o,
  output icache_pkg::word_t  mem_q_o,
  input  logic               hit_i,
  input  icache_pkg::word_t  hit_word_i,
  output icache_pkg::idx_t   rd_idx_o,
  output icache_pkg::wsel_t  rd_wsel_o,
  output icache_pkg::tag_t   cmp_tag_o,
  output logic               fill_start_o,
  output icache_pkg::addr_t  fill_adr_o,
  input  logic               fill_done_i,
  input  logic               fill_err_i,
  input  icache_pkg::line_t  fill_line_i,
  output logic               wr_o,
  output icache_pkg::idx_t   wr_idx_o,
  output icache_pkg::tag_t   wr_tag_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {ARMED, FILL, RECOVER} ctrl_state_e;

  ctrl_state_e state_q;
  logic        pend_q;   // request accepted and not yet answered
  logic        err_q;    // RECOVER answers with an error
  addr_t       adr_q;
  line_t       line_q;   // filled line that feeds the miss answer
  addr_t       rd_adr;

  // live address on a request and the held one otherwise
  assign rd_adr    = mem_req_i ? mem_adr_i : adr_q;
  assign rd_idx_o  = adr_idx(rd_adr);
  assign rd_wsel_o = adr_wsel(rd_adr);
  assign cmp_tag_o = adr_tag(rd_adr);

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ARMED;
      pend_q  <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      pend_q <= mem_req_i | (pend_q & ~mem_ack_o & ~mem_err_o);
      case (state_q)
        ARMED:
        begin
          if (fill_start_o)
          begin
            state_q <= FILL;
          end
        end
        FILL:
        begin
          if (fill_err_i || fill_done_i)
          begin
            state_q <= RECOVER;
            err_q   <= fill_err_i;
          end
        end
        RECOVER: state_q <= ARMED;  // RAM port free again
        default: state_q <= ARMED;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_req_i)
    begin
      adr_q <= mem_adr_i;
    end
    if (state_q == FILL && fill_done_i)
    begin
      line_q <= fill_line_i;
    end
  end

  assign fill_start_o = (state_q == ARMED) & pend_q & ~hit_i;  // miss seen
  assign fill_adr_o   = adr_q;

  // install in the done cycle into the way the fill engine chose
  assign wr_o     = (state_q == FILL) & fill_done_i;
  assign wr_idx_o = adr_idx(adr_q);
  assign wr_tag_o = adr_tag(adr_q);

  // ----------------------------------------
  // CPU responses
  // ----------------------------------------
  assign mem_ack_o = ((state_q == ARMED) & pend_q & hit_i) | ((state_q == RECOVER) & ~err_q);
  assign mem_err_o = (state_q == RECOVER) & err_q;
  assign mem_q_o   = (state_q == RECOVER) ? word_t'(line_q >> (adr_wsel(adr_q) * XLEN))
                                          : hit_word_i;

  a_one_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |-> !pend_q);

  // every answer belongs to a pending request
  a_rsp_pend: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_ack_o || mem_err_o) |-> pend_q);

endmodule

`default_nettype wire

/* design/icache_data_ways.sv */
// line store per way with hit-way mux and word select
`default_nettype none

module icache_data_ways (
  input  logic                   clk_i,
  input  icache_pkg::idx_t       rd_idx_i,
  input  icache_pkg::wsel_t      rd_wsel_i,
  input  icache_pkg::way_mask_t  hit_way_i,
  input  logic                   wr_i,
  input  icache_pkg::way_mask_t  wr_way_i,
  input  icache_pkg::idx_t       wr_idx_i,
  input  icache_pkg::line_t      wr_line_i,
  output icache_pkg::word_t      word_o
);

  import icache_pkg::*;

  idx_t  ram_idx;
  wsel_t wsel_q;            // follows the RAM read by one cycle
  line_t line_rd [WAYS];
  line_t line_mux;

  assign ram_idx = wr_i ? wr_idx_i : rd_idx_i;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    icache_ram #(
      .payload_t(line_t)
    ) u_line_ram (
      .clk_i  (clk_i),
      .addr_i (ram_idx),
      .we_i   (wr_i & wr_way_i[w]),
      .din_i  (wr_line_i),
      .dout_o (line_rd[w])
    );
  end

  always_ff @(posedge clk_i)
  begin
    wsel_q <= rd_wsel_i;
  end

  // AND-OR mux, hit_way is at most one-hot
  always_comb
  begin
    line_mux = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      line_mux |= line_rd[w] & {$bits(line_t){hit_way_i[w]}};
    end
  end

  assign word_o = word_t'(line_mux >> (wsel_q * XLEN));  // word 0 sits at the bottom

endmodule

`default_nettype wire

/* design/icache_fill.sv */
// line fill engine running wrap bursts on the bus with LFSR victim choice
`default_nettype none

module icache_fill (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  icache_pkg::addr_t      adr_i,
  output icache_pkg::biu_req_t   biu_req_o,
  input  icache_pkg::biu_rsp_t   biu_rsp_i,
  output icache_pkg::line_t      line_o,
  output logic                   done_o,
  output logic                   err_o,
  output icache_pkg::way_mask_t  victim_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT4BIU, BURST} fill_state_e;

  fill_state_e state_q;
  addr_t       adr_q;      // word aligned start address
  wsel_t       cnt_q;      // remaining beats less one
  line_t       buf_q;
  logic [19:0] lfsr_q;
  way_mask_t   victim_q;
  logic        beat;

  assign beat = (state_q == BURST) & biu_rsp_i.ack;

  // ----------------------------------------
  // burst FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      victim_q <= way_mask_t'(1);
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (start_i)
          begin
            state_q  <= WAIT4BIU;
            cnt_q    <= wsel_t'(BURST_LEN - 1);
            victim_q <= way_mask_t'(1) << lfsr_q[0];  // frozen for this fill
          end
        end
        WAIT4BIU:
        begin
          if (biu_rsp_i.stb_ack)
          begin
            state_q <= BURST;
          end
        end
        BURST:
        begin
          if (biu_rsp_i.err || (beat && cnt_q == '0))
          begin
            state_q <= IDLE;  // error ends the burst early
          end
          else if (beat)
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && start_i)
    begin
      adr_q <= {adr_i[XLEN-1:2], 2'b00};
    end
    if (beat)
    begin
      buf_q[adr_wsel(biu_rsp_i.adro)*XLEN +: XLEN] <= biu_rsp_i.q;  // wrap order
    end
  end

  // pseudo-random victim source that runs only between fills
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lfsr_q <= '0;
    end
    else if (state_q == IDLE)
    begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign biu_req_o.stb = (state_q == WAIT4BIU);
  assign biu_req_o.adr = adr_q;

  // last beat merged in so the line is whole with done_o
  always_comb
  begin
    line_o = buf_q;
    if (beat)
    begin
      line_o[adr_wsel(biu_rsp_i.adro)*XLEN +: XLEN] = biu_rsp_i.q;
    end
  end

  assign done_o   = beat & (cnt_q == '0);
  assign err_o    = (state_q == BURST) & biu_rsp_i.err;
  assign victim_o = victim_q;

  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_req_o.stb && !biu_rsp_i.stb_ack |=> biu_req_o.stb && $stable(biu_req_o.adr));

  a_done_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(done_o && err_o));

endmodule

`default_nettype wire

/* design/icache_lookup.sv */
// tag store per way with valid flops, flush clear and hit compare
`default_nettype none

module icache_lookup (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::idx_t       rd_idx_i,
  input  icache_pkg::tag_t       cmp_tag_i,
  input  logic                   wr_i,
  input  icache_pkg::way_mask_t  wr_way_i,
  input  icache_pkg::idx_t       wr_idx_i,
  input  icache_pkg::tag_t       wr_tag_i,
  input  logic                   flush_i,
  output logic                   hit_o,
  output icache_pkg::way_mask_t  hit_way_o
);

  import icache_pkg::*;

  logic [WAYS-1:0][SETS-1:0] valid_q;
  idx_t                      rd_idx_q;   // lines valid up with tag RAM output
  tag_t                      cmp_tag_q;
  idx_t                      ram_idx;
  tag_t                      tag_rd [WAYS];

  assign ram_idx = wr_i ? wr_idx_i : rd_idx_i;  // install wins the port

  // ----------------------------------------
  // valid bits
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;  // whole cache in one cycle
    end
    else if (wr_i)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (wr_way_i[w])
        begin
          valid_q[w][wr_idx_i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_idx_q <= '0;
    end
    else
    begin
      rd_idx_q <= rd_idx_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    cmp_tag_q <= cmp_tag_i;
  end

  // ----------------------------------------
  // tag RAMs and compare
  // ----------------------------------------
  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    icache_ram #(
      .payload_t(tag_t)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .addr_i (ram_idx),
      .we_i   (wr_i & wr_way_i[w]),
      .din_i  (wr_tag_i),
      .dout_o (tag_rd[w])
    );

    assign hit_way_o[w] = valid_q[w][rd_idx_q] & (tag_rd[w] == cmp_tag_q);
  end

  assign hit_o = |hit_way_o;

  // a line is only ever installed on a miss, so no set holds a tag twice
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_way_o));

  // victim comes from the fill engine
  a_wr_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_i |-> $onehot(wr_way_i));

endmodule

`default_nettype wire

/* design/icache_pkg.sv */
// shared geometry, address field types and bus structs of the instruction cache
`default_nettype none

package icache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int XLEN       = 32;                 // word and address width
  localparam int LINE_BYTES = 16;
  localparam int WAYS       = 2;
  localparam int SETS       = 32;
  localparam int BURST_LEN  = LINE_BYTES / (XLEN / 8);  // beats per line fill
  localparam int OFF_BITS   = $clog2(LINE_BYTES);       // byte offset in line
  localparam int WSEL_BITS  = $clog2(BURST_LEN);        // word within line
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int TAG_BITS   = XLEN - IDX_BITS - OFF_BITS;

  // ----------------------------------------
  // address and data types
  // ----------------------------------------
  typedef logic [XLEN-1:0]         addr_t;
  typedef logic [XLEN-1:0]         word_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;     // word n at bits n*XLEN upward
  typedef logic [IDX_BITS-1:0]     idx_t;
  typedef logic [TAG_BITS-1:0]     tag_t;
  typedef logic [WSEL_BITS-1:0]    wsel_t;
  typedef logic [WAYS-1:0]         way_mask_t; // one-hot

  // bus request towards the memory side
  typedef struct packed {
    logic  stb;   // burst request, held until stb_ack
    addr_t adr;   // word address of the first beat
  } biu_req_t;

  // bus response
  typedef struct packed {
    logic  stb_ack; // burst accepted
    logic  ack;     // one beat valid
    logic  err;     // beat error, ends the burst
    addr_t adro;    // address of this beat
    word_t q;
  } biu_rsp_t;

  // ----------------------------------------
  // address field helpers
  // ----------------------------------------
  function automatic idx_t adr_idx(input addr_t a);
    return a[OFF_BITS +: IDX_BITS];
  endfunction

  function automatic tag_t adr_tag(input addr_t a);
    return a[XLEN-1 -: TAG_BITS];
  endfunction

  function automatic wsel_t adr_wsel(input addr_t a);
    return a[OFF_BITS-1 -: WSEL_BITS];
  endfunction

endpackage

`default_nettype wire

/* design/icache_ram.sv */
// single-port synchronous RAM holding one payload word per cache set
`default_nettype none

module icache_ram #(
  parameter type payload_t = icache_pkg::word_t
) (
  input  logic              clk_i,
  input  icache_pkg::idx_t  addr_i,
  input  logic              we_i,
  input  payload_t          din_i,
  output payload_t          dout_o
);

  import icache_pkg::*;

  payload_t mem_q [SETS];  // one entry per set

  // write and registered read share the one port
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_q[addr_i] <= din_i;
    end
    dout_o <= mem_q[addr_i];  // old data on a write cycle
  end

endmodule

`default_nettype wire

/* design/icache_top.sv */
// instruction cache top joining control, tag lookup, line store and fill engine
`default_nettype none

module icache_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mem_req_i,
  input  icache_pkg::addr_t     mem_adr_i,
  input  logic                  flush_i,
  output logic                  mem_ack_o,
  output logic                  mem_err_o,
  output icache_pkg::word_t     mem_q_o,
  output icache_pkg::biu_req_t  biu_req_o,
  input  icache_pkg::biu_rsp_t  biu_rsp_i
);

  import icache_pkg::*;

  // ----------------------------------------
  // internal nets
  // ----------------------------------------
  idx_t      rd_idx;
  wsel_t     rd_wsel;
  tag_t      cmp_tag;
  logic      hit;
  way_mask_t hit_way;
  word_t     hit_word;
  logic      fill_start;
  addr_t     fill_adr;
  logic      fill_done;
  logic      fill_err;
  line_t     fill_line;
  way_mask_t victim;     // install way
  logic      wr;
  idx_t      wr_idx;
  tag_t      wr_tag;

  icache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_i),
    .mem_adr_i    (mem_adr_i),
    .mem_ack_o    (mem_ack_o),
    .mem_err_o    (mem_err_o),
    .mem_q_o      (mem_q_o),
    .hit_i        (hit),
    .hit_word_i   (hit_word),
    .rd_idx_o     (rd_idx),
    .rd_wsel_o    (rd_wsel),
    .cmp_tag_o    (cmp_tag),
    .fill_start_o (fill_start),
    .fill_adr_o   (fill_adr),
    .fill_done_i  (fill_done),
    .fill_err_i   (fill_err),
    .fill_line_i  (fill_line),
    .wr_o         (wr),
    .wr_idx_o     (wr_idx),
    .wr_tag_o     (wr_tag)
  );

  icache_lookup u_lookup (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_idx_i  (rd_idx),
    .cmp_tag_i (cmp_tag),
    .wr_i      (wr),
    .wr_way_i  (victim),
    .wr_idx_i  (wr_idx),
    .wr_tag_i  (wr_tag),
    .flush_i   (flush_i),
    .hit_o     (hit),
    .hit_way_o (hit_way)
  );

  icache_data_ways u_data_ways (
    .clk_i     (clk_i),
    .rd_idx_i  (rd_idx),
    .rd_wsel_i (rd_wsel),
    .hit_way_i (hit_way),
    .wr_i      (wr),
    .wr_way_i  (victim),
    .wr_idx_i  (wr_idx),
    .wr_line_i (fill_line),   // whole line incl. last beat
    .word_o    (hit_word)
  );

  icache_fill u_fill (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (fill_start),
    .adr_i     (fill_adr),
    .biu_req_o (biu_req_o),
    .biu_rsp_i (biu_rsp_i),
    .line_o    (fill_line),
    .done_o    (fill_done),
    .err_o     (fill_err),
    .victim_o  (victim)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_icache \
  -f sim.f \
  --Mdir obj_dir \
  -o tb_icache_sim

./obj_dir/tb_icache_sim | tee sim.log

# the run passes only if the pass line is in the log
grep -q "Everything OK" sim.log

/* sim.f */
design/icache_pkg.sv
design/icache_ram.sv
design/icache_lookup.sv
design/icache_data_ways.sv
design/icache_fill.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/tb_mem.sv
tb/tb_icache.sv

/* tb/tb_icache.sv */
// testbench for the instruction cache with directed read, flush, error and stall tests
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  // ----------------------------------------
  // run limits
  // ----------------------------------------
  localparam int STALL_CYCLES    = 6;
  localparam int N_READS         = 20;   // reads over all tests rounded up
  localparam int MAX_READ_CYCLES = 20;   // stalled miss with margin
  localparam int TIMEOUT_CYCLES  = N_READS * MAX_READ_CYCLES * 10;

  // one CPU read as seen by the testbench
  typedef struct packed {
    logic        ack;
    logic        err;
    word_t       q;
    logic [31:0] lat;  // cycles from request to answer
  } rd_rsp_t;

  logic     clk;
  logic     rst_n;
  logic     mem_req;
  addr_t    mem_adr;
  logic     flush;
  logic     mem_ack;
  logic     mem_err;
  word_t    mem_q;
  biu_req_t biu_req;
  biu_rsp_t biu_rsp;
  int       stall;
  logic     err_en;
  addr_t    err_line;
  int       strobes;
  int       adr_faults;

  int       errors;
  int       checks;
  int       cycle_cnt;
  addr_t    t1_adr;       // reused by the flush test
  addr_t    beat_adrs [$];
  int       stb_cycles;
  addr_t    stb_adr;      // last adr seen with stb

  icache_top uut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .mem_req_i (mem_req),
    .mem_adr_i (mem_adr),
    .flush_i   (flush),
    .mem_ack_o (mem_ack),
    .mem_err_o (mem_err),
    .mem_q_o   (mem_q),
    .biu_req_o (biu_req),
    .biu_rsp_i (biu_rsp)
  );

  tb_mem u_mem (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .biu_req_i    (biu_req),
    .biu_rsp_o    (biu_rsp),
    .stall_i      (stall),
    .err_en_i     (err_en),
    .err_line_i   (err_line),
    .strobes_o    (strobes),
    .adr_faults_o (adr_faults)
  );

  always #5 clk = ~clk;

  // bus monitor sampling mid-cycle
  always @(negedge clk)
  begin
    if (biu_rsp.ack)
    begin
      beat_adrs.push_back(biu_rsp.adro);
    end
    if (biu_req.stb)
    begin
      stb_cycles++;
      stb_adr = biu_req.adr;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // expected memory content
  function automatic word_t expected_word(input addr_t a);
    return (a ^ 32'h5a5a_0000) + {a[24:0], a[31:25]};
  endfunction

  function automatic addr_t make_adr(input tag_t t, input idx_t i, input wsel_t w);
    return {t, i, w, 2'b00};
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_adr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  // one request pulse and a wait for ack or err
  task automatic read_word(input addr_t a, output rd_rsp_t r);
    @(negedge clk);
    mem_req = 1'b1;
    mem_adr = a;
    r = '0;
    do
    begin
      @(negedge clk);
      mem_req = 1'b0;
      r.lat = r.lat + 1;
    end
    while (!(mem_ack || mem_err));
    r.ack = mem_ack;
    r.err = mem_err;
    r.q   = mem_q;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_miss_then_hit();
    rd_rsp_t r;
    int      s0;
    t1_adr = make_adr(tag_t'($urandom), idx_t'(1), wsel_t'(1));
    s0 = strobes;
    read_word(t1_adr, r);
    check_count(strobes - s0, 1, "first read strobes once");
    check_adr(stb_adr, t1_adr, "burst starts at the requested word");
    check_flag(r.ack, 1'b1, "miss acknowledged");
    check_word(r.q, expected_word(t1_adr), "miss data");
    read_word(t1_adr, r);
    check_count(int'(r.lat), 1, "hit latency");
    check_count(strobes - s0, 1, "hit adds no strobe");
    check_word(r.q, expected_word(t1_adr), "hit data");
  endtask

  task automatic test_line_wrap();
    rd_rsp_t r;
    tag_t    t;
    addr_t   a;
    addr_t   aw;
    t = tag_t'($urandom);
    a = make_adr(t, idx_t'(2), wsel_t'(2));
    beat_adrs.delete();
    read_word(a, r);
    check_word(r.q, expected_word(a), "wrap fill data");
    check_count(beat_adrs.size(), BURST_LEN, "beats per fill");
    for (int i = 0; i < BURST_LEN && i < beat_adrs.size(); i++)
    begin
      check_adr(beat_adrs[i], make_adr(t, idx_t'(2), wsel_t'(2 + i)),
                "beat address order");
    end
    for (int w = 0; w < BURST_LEN; w++)
    begin
      aw = make_adr(t, idx_t'(2), wsel_t'(w));
      read_word(aw, r);
      check_count(int'(r.lat), 1, "line word hits");
      check_word(r.q, expected_word(aw), "line word data");
    end
  endtask

  task automatic test_set_conflict();
    rd_rsp_t r;
    addr_t   a [3];
    tag_t    t;
    int      s0;
    t = tag_t'($urandom);
    for (int i = 0; i < 3; i++)
    begin
      a[i] = make_adr(t + tag_t'(i), idx_t'(3), wsel_t'($urandom));  // same set
    end
    for (int i = 0; i < 3; i++)
    begin
      read_word(a[i], r);
      check_flag(r.ack, 1'b1, "conflict read acknowledged");
      check_word(r.q, expected_word(a[i]), "conflict read data");
    end
    s0 = strobes;
    for (int i = 0; i < 3; i++)
    begin
      read_word(a[i], r);
      check_word(r.q, expected_word(a[i]), "conflict reread data");
    end
    check_flag(strobes - s0 >= 1, 1'b1, "three lines do not fit in two ways");
  endtask

  task automatic test_flush();
    rd_rsp_t r;
    int      s0;
    s0 = strobes;
    read_word(t1_adr, r);
    check_count(strobes - s0, 0, "line still cached before flush");
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    read_word(t1_adr, r);
    check_count(strobes - s0, 1, "flushed line fetched again");
    check_word(r.q, expected_word(t1_adr), "data after flush");
  endtask

  task automatic test_bus_error();
    rd_rsp_t r;
    addr_t   a;
    int      s0;
    a = make_adr(tag_t'($urandom), idx_t'(5), wsel_t'(3));
    err_line = {a[XLEN-1:OFF_BITS], {OFF_BITS{1'b0}}};
    err_en = 1'b1;
    s0 = strobes;
    read_word(a, r);
    check_flag(r.err, 1'b1, "error beat reported");
    check_flag(r.ack, 1'b0, "no ack with the error");
    repeat (3)
    begin
      @(negedge clk);
      check_flag(mem_ack, 1'b0, "no late ack after error");
    end
    err_en = 1'b0;
    read_word(a, r);
    check_count(strobes - s0, 2, "failed line not installed");
    check_flag(r.ack, 1'b1, "retry acknowledged");
    check_word(r.q, expected_word(a), "retry data");
  endtask

  task automatic test_stall();
    rd_rsp_t r;
    addr_t   a;
    int      s0;
    int      f0;
    a = make_adr(tag_t'($urandom), idx_t'(6), wsel_t'(0));
    stall = STALL_CYCLES;
    stb_cycles = 0;
    s0 = strobes;
    f0 = adr_faults;
    read_word(a, r);
    stall = 0;
    check_count(strobes - s0, 1, "stalled burst strobes once");
    check_count(stb_cycles, STALL_CYCLES + 2, "stb held through the stall");
    check_adr(stb_adr, a, "stalled burst address");
    check_count(adr_faults - f0, 0, "stb address stable while stalled");
    check_word(r.q, expected_word(a), "stalled read data");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(32'hba93));
    clk        = 1'b0;
    rst_n      = 1'b0;
    mem_req    = 1'b0;
    mem_adr    = '0;
    flush      = 1'b0;
    stall      = 0;
    err_en     = 1'b0;
    err_line   = '0;
    errors     = 0;
    checks     = 0;
    cycle_cnt  = 0;
    stb_cycles = 0;
    stb_adr    = '0;
    repeat (2) @(negedge clk);  // two cycles in reset
    rst_n = 1'b1;

    test_miss_then_hit();
    test_line_wrap();
    test_set_conflict();
    test_flush();
    test_bus_error();
    test_stall();

    repeat (2) @(negedge clk);
    $display("summary: %0d checks, %0d errors, %0d bus address faults",
             checks, errors, adr_faults);
    if (errors == 0 && adr_faults == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_mem.sv */
// bus memory model answering wrap bursts, with stb_ack stall and error injection
`default_nettype none

module tb_mem (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  icache_pkg::biu_req_t  biu_req_i,
  output icache_pkg::biu_rsp_t  biu_rsp_o,
  input  int                    stall_i,      // cycles stb_ack is held back
  input  logic                  err_en_i,
  input  icache_pkg::addr_t     err_line_i,   // line base that errs on beat 0
  output int                    strobes_o,    // accepted bursts
  output int                    adr_faults_o  // adr moved while stalled
);

  import icache_pkg::*;

  logic  busy_q;      // burst in progress
  int    wait_q;      // stall cycles spent so far
  int    beat_q;      // next beat number
  addr_t first_q;     // requested word of the burst
  addr_t held_adr_q;

  // memory content, a pure function of the address
  function automatic word_t data_at(input addr_t a);
    return (a ^ 32'h5a5a_0000) + {a[24:0], a[31:25]};
  endfunction

  // beat n of a wrap burst stays inside the line
  function automatic addr_t beat_adr(input addr_t first, input int n);
    return {first[XLEN-1:OFF_BITS], wsel_t'(adr_wsel(first) + n), 2'b00};
  endfunction

  // ----------------------------------------
  // burst responder
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q       <= 1'b0;
      wait_q       <= 0;
      beat_q       <= 0;
      first_q      <= '0;
      held_adr_q   <= '0;
      strobes_o    <= 0;
      adr_faults_o <= 0;
      biu_rsp_o    <= '0;
    end
    else
    begin
      biu_rsp_o.stb_ack <= 1'b0;  // all strobes are one cycle
      biu_rsp_o.ack     <= 1'b0;
      biu_rsp_o.err     <= 1'b0;
      if (!busy_q && biu_req_i.stb)
      begin
        if (wait_q > 0 && biu_req_i.adr != held_adr_q)
        begin
          $display("bus address changed from %h to %h while stb_ack was held back, at %0t",
                   held_adr_q, biu_req_i.adr, $time);
          adr_faults_o <= adr_faults_o + 1;
        end
        held_adr_q <= biu_req_i.adr;
        if (wait_q >= stall_i)
        begin
          biu_rsp_o.stb_ack <= 1'b1;
          first_q           <= biu_req_i.adr;
          strobes_o         <= strobes_o + 1;
          wait_q            <= 0;
          beat_q            <= 0;
          busy_q            <= 1'b1;
        end
        else
        begin
          wait_q <= wait_q + 1;  // stall one more cycle
        end
      end
      else if (busy_q)
      begin
        if (beat_q == BURST_LEN)
        begin
          busy_q <= 1'b0;
        end
        else if (beat_q == 0 && err_en_i
                 && {first_q[XLEN-1:OFF_BITS], {OFF_BITS{1'b0}}} == err_line_i)
        begin
          biu_rsp_o.err  <= 1'b1;                 // first beat fails, burst over
          biu_rsp_o.adro <= beat_adr(first_q, 0);
          busy_q         <= 1'b0;
        end
        else
        begin
          biu_rsp_o.ack  <= 1'b1;
          biu_rsp_o.adro <= beat_adr(first_q, beat_q);
          biu_rsp_o.q    <= data_at(beat_adr(first_q, beat_q));
          beat_q         <= beat_q + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire
